/* src/cpu_defs.svh */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// architectural widths and sizes
`define XLEN        32
`define REG_COUNT   32
`define REG_IDX_W   5
`define ALU_CTRL_W  4
`define IMEM_WORDS  256
`define DMEM_WORDS  256

// rv32i opcodes, subset only
`define OP_RTYPE    7'b0110011
`define OP_ITYPE    7'b0010011
`define OP_LOAD     7'b0000011
`define OP_STORE    7'b0100011
`define OP_BRANCH   7'b1100011
`define OP_JAL      7'b1101111
`define OP_JALR     7'b1100111
`define OP_SYSTEM   7'b1110011

// funct3 values
`define F3_ADD_SUB  3'b000
`define F3_SLT      3'b010
`define F3_XOR      3'b100
`define F3_OR       3'b110
`define F3_AND      3'b111
`define F3_BEQ      3'b000
`define F3_BNE      3'b001

// alu ops, EQ and NE only feed the branch condition
`define ALU_ADD     4'd0
`define ALU_SUB     4'd1
`define ALU_AND     4'd2
`define ALU_OR      4'd3
`define ALU_XOR     4'd4
`define ALU_SLT     4'd5
`define ALU_EQ      4'd6
`define ALU_NE      4'd7

`define ECALL_REG   5'd17   // a7
`define HALT_CODE   32'd10
`define RESET_PC    32'h0000_0000

`endif

/* src/cpu_pkg.sv */
`include "cpu_defs.svh"

package cpu_pkg;

  // data word or byte address
  typedef logic [`XLEN-1:0] word_t;

  // register number
  typedef logic [`REG_IDX_W-1:0] reg_idx_t;

  // raw instruction word
  typedef logic [`XLEN-1:0] inst_t;

  // alu operation select
  typedef logic [`ALU_CTRL_W-1:0] alu_ctrl_t;

  // word index into instruction memory
  typedef logic [$clog2(`IMEM_WORDS)-1:0] imem_addr_t;

endpackage

/* src/fetch_stage.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module fetch_stage import cpu_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       prog_we,      // program load, honored during reset only
  input  imem_addr_t prog_addr,
  input  inst_t      prog_data,
  input  logic       hazard_stall,
  input  logic       redirect,
  input  word_t      redirect_pc,
  output inst_t      id_inst,
  output word_t      id_pc
);

  word_t      pc;
  imem_addr_t fetch_idx;
  inst_t      imem [`IMEM_WORDS];

  assign fetch_idx = pc[$bits(imem_addr_t)+1:2];  // word index

  // pc, always predicts not-taken
  always_ff @(posedge clk) begin
    if (reset)
      pc <= `RESET_PC;
    else if (redirect)              // redirect wins over stall
      pc <= redirect_pc;
    else if (!hazard_stall)
      pc <= pc + word_t'(4);
  end

  always_ff @(posedge clk) begin
    if (reset && prog_we)
      imem[prog_addr] <= prog_data;
  end

  // IF/ID, all-zero word decodes as a bubble
  always_ff @(posedge clk) begin
    if (reset || redirect) begin
      id_inst <= '0;
      id_pc   <= '0;
    end else if (!hazard_stall) begin
      id_inst <= imem[fetch_idx];
      id_pc   <= pc;
    end
  end

endmodule

/* src/register_file.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module register_file import cpu_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  reg_idx_t rs1_idx,
  input  reg_idx_t rs2_idx,
  input  reg_idx_t rd_idx,
  input  reg_idx_t dbg_reg_idx,
  input  word_t    rd_data,
  input  logic     reg_write,
  output word_t    rs1_data,
  output word_t    rs2_data,
  output word_t    dbg_reg_data
);

  word_t regs [`REG_COUNT];
  logic  wr_live;

  assign wr_live = reg_write && (rd_idx != '0);  // x0 stays zero

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `REG_COUNT; i++)
        regs[i] <= '0;
    end else if (wr_live) begin
      regs[rd_idx] <= rd_data;
    end
  end

  // write-through so decode sees the retiring value
  assign rs1_data = (wr_live && rd_idx == rs1_idx) ? rd_data : regs[rs1_idx];
  assign rs2_data = (wr_live && rd_idx == rs2_idx) ? rd_data : regs[rs2_idx];

  assign dbg_reg_data = regs[dbg_reg_idx];  // stored value, no bypass

endmodule

/* src/decode_stage.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module decode_stage import cpu_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  inst_t     id_inst,
  input  word_t     id_pc,
  input  logic      redirect,
  input  word_t     rs1_data,
  input  word_t     rs2_data,
  input  reg_idx_t  mem_rd,          // EX/MEM destination, ecall check
  input  logic      mem_reg_write,
  output reg_idx_t  rs1_idx,
  output reg_idx_t  rs2_idx,
  output logic      hazard_stall,
  output alu_ctrl_t ex_alu_ctrl,
  output reg_idx_t  ex_rs1,
  output reg_idx_t  ex_rs2,
  output reg_idx_t  ex_rd,
  output word_t     ex_rs1_data,
  output word_t     ex_rs2_data,
  output word_t     ex_imm,
  output word_t     ex_pc,
  output logic      ex_alu_src,
  output logic      ex_mem_read,
  output logic      ex_mem_write,
  output logic      ex_reg_write,
  output logic      ex_pc_to_reg,
  output logic      ex_branch,
  output logic      ex_jal,
  output logic      ex_jalr,
  output logic      ex_halt
);

  logic [2:0] funct3;
  alu_ctrl_t  alu_ctrl;
  word_t      imm;
  logic       alu_src, mem_read, mem_write, reg_write, pc_to_reg;
  logic       branch, jal, jalr, is_ecall;
  logic       load_use, ecall_wait;

  assign funct3  = id_inst[14:12];
  assign rs1_idx = is_ecall ? `ECALL_REG : id_inst[19:15];  // ecall reads a7
  assign rs2_idx = id_inst[24:20];

  // main control and immediate select
  always_comb begin
    {alu_src, mem_read, mem_write, reg_write, pc_to_reg} = '0;
    {branch, jal, jalr, is_ecall} = '0;
    alu_ctrl = `ALU_ADD;
    imm      = {{20{id_inst[31]}}, id_inst[31:20]};  // I form unless overridden
    case (id_inst[6:0])
      `OP_RTYPE: begin
        reg_write = 1'b1;
        case (funct3)
          `F3_ADD_SUB: alu_ctrl = id_inst[30] ? `ALU_SUB : `ALU_ADD;
          `F3_SLT:     alu_ctrl = `ALU_SLT;
          `F3_XOR:     alu_ctrl = `ALU_XOR;
          `F3_OR:      alu_ctrl = `ALU_OR;
          `F3_AND:     alu_ctrl = `ALU_AND;
          default:     alu_ctrl = `ALU_ADD;
        endcase
      end
      `OP_ITYPE: {alu_src, reg_write} = 2'b11;  // addi only
      `OP_LOAD:  {alu_src, mem_read, reg_write} = 3'b111;
      `OP_STORE: begin
        {alu_src, mem_write} = 2'b11;
        imm = {{20{id_inst[31]}}, id_inst[31:25], id_inst[11:7]};
      end
      `OP_BRANCH: begin
        branch   = 1'b1;
        alu_ctrl = (funct3 == `F3_BNE) ? `ALU_NE : `ALU_EQ;
        imm = {{19{id_inst[31]}}, id_inst[31], id_inst[7], id_inst[30:25],
               id_inst[11:8], 1'b0};
      end
      `OP_JAL: begin
        {jal, reg_write, pc_to_reg} = 3'b111;
        imm = {{11{id_inst[31]}}, id_inst[31], id_inst[19:12], id_inst[20],
               id_inst[30:21], 1'b0};
      end
      `OP_JALR:   {jalr, alu_src, reg_write, pc_to_reg} = 4'b1111;
      `OP_SYSTEM: is_ecall = 1'b1;
      default: ;                              // bubble or unknown, no effect
    endcase
  end

  // load result not ready for the next instruction
  assign load_use = ex_mem_read && (ex_rd != '0) &&
                    (ex_rd == rs1_idx || ex_rd == rs2_idx);
  // a7 still in flight, wait until it can come through the regfile bypass
  assign ecall_wait = is_ecall &&
                      ((ex_reg_write && ex_rd == `ECALL_REG) ||
                       (mem_reg_write && mem_rd == `ECALL_REG));
  assign hazard_stall = load_use || ecall_wait;

  // ID/EX control, bubbled on flush or stall
  always_ff @(posedge clk) begin
    if (reset || redirect || hazard_stall) begin
      {ex_alu_src, ex_mem_read, ex_mem_write, ex_reg_write, ex_pc_to_reg} <= '0;
      {ex_branch, ex_jal, ex_jalr, ex_halt} <= '0;
    end else begin
      {ex_alu_src, ex_mem_read, ex_mem_write} <= {alu_src, mem_read, mem_write};
      {ex_reg_write, ex_pc_to_reg} <= {reg_write, pc_to_reg};
      {ex_branch, ex_jal, ex_jalr} <= {branch, jal, jalr};
      ex_halt <= is_ecall && (rs1_data == `HALT_CODE);
    end
  end

  // ID/EX payload
  always_ff @(posedge clk) begin
    ex_alu_ctrl <= alu_ctrl;
    ex_rs1      <= rs1_idx;
    ex_rs2      <= rs2_idx;
    ex_rd       <= id_inst[11:7];
    ex_rs1_data <= rs1_data;
    ex_rs2_data <= rs2_data;
    ex_imm      <= imm;
    ex_pc       <= id_pc;
  end

endmodule

/* src/execute_stage.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module execute_stage import cpu_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  alu_ctrl_t ex_alu_ctrl,
  input  reg_idx_t  ex_rs1,
  input  reg_idx_t  ex_rs2,
  input  reg_idx_t  ex_rd,
  input  word_t     ex_rs1_data,
  input  word_t     ex_rs2_data,
  input  word_t     ex_imm,
  input  word_t     ex_pc,
  input  logic      ex_alu_src,
  input  logic      ex_mem_read,
  input  logic      ex_mem_write,
  input  logic      ex_reg_write,
  input  logic      ex_pc_to_reg,
  input  logic      ex_branch,
  input  logic      ex_jal,
  input  logic      ex_jalr,
  input  logic      ex_halt,
  input  reg_idx_t  wb_rd,
  input  logic      wb_reg_write,
  input  word_t     wb_data,
  output logic      redirect,
  output word_t     redirect_pc,
  output word_t     mem_alu_out,
  output word_t     mem_store_data,
  output word_t     mem_pc_plus4,
  output reg_idx_t  mem_rd,
  output logic      mem_read,
  output logic      mem_write,
  output logic      mem_reg_write,
  output logic      mem_pc_to_reg,
  output logic      mem_halt
);

  word_t mem_fwd, op_a, rs2_fwd, op_b, alu_result;

  // forwarding mux, memory stage first, x0 never forwarded
  function automatic word_t fwd_sel(reg_idx_t idx, word_t reg_val);
    if (mem_reg_write && mem_rd != '0 && mem_rd == idx)
      return mem_fwd;
    else if (wb_reg_write && wb_rd != '0 && wb_rd == idx)
      return wb_data;
    return reg_val;
  endfunction

  assign mem_fwd = mem_pc_to_reg ? mem_pc_plus4 : mem_alu_out;  // link value for jumps
  assign op_a    = fwd_sel(ex_rs1, ex_rs1_data);
  assign rs2_fwd = fwd_sel(ex_rs2, ex_rs2_data);
  assign op_b    = ex_alu_src ? ex_imm : rs2_fwd;

  always_comb begin
    case (ex_alu_ctrl)
      `ALU_SUB: alu_result = op_a - op_b;
      `ALU_AND: alu_result = op_a & op_b;
      `ALU_OR:  alu_result = op_a | op_b;
      `ALU_XOR: alu_result = op_a ^ op_b;
      `ALU_SLT: alu_result = word_t'($signed(op_a) < $signed(op_b));
      `ALU_EQ:  alu_result = word_t'(op_a == op_b);   // bit 0 is the branch condition
      `ALU_NE:  alu_result = word_t'(op_a != op_b);
      default:  alu_result = op_a + op_b;
    endcase
  end

  // resolved here, flushes IF/ID and ID/EX
  assign redirect    = ex_jal || ex_jalr || (ex_branch && alu_result[0]);
  assign redirect_pc = ex_jalr ? {alu_result[`XLEN-1:1], 1'b0} : ex_pc + ex_imm;

  always_ff @(posedge clk) begin
    if (reset) begin
      {mem_read, mem_write, mem_reg_write, mem_pc_to_reg, mem_halt} <= '0;
    end else begin
      {mem_read, mem_write, mem_reg_write} <= {ex_mem_read, ex_mem_write, ex_reg_write};
      {mem_pc_to_reg, mem_halt} <= {ex_pc_to_reg, ex_halt};
    end
  end

  // EX/MEM payload
  always_ff @(posedge clk) begin
    mem_alu_out    <= alu_result;
    mem_store_data <= rs2_fwd;         // forwarded store value
    mem_pc_plus4   <= ex_pc + word_t'(4);
    mem_rd         <= ex_rd;
  end

endmodule

/* src/memory_stage.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module memory_stage import cpu_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  word_t    mem_alu_out,
  input  word_t    mem_store_data,
  input  word_t    mem_pc_plus4,
  input  reg_idx_t mem_rd,
  input  logic     mem_read,
  input  logic     mem_write,
  input  logic     mem_reg_write,
  input  logic     mem_pc_to_reg,
  input  logic     mem_halt,
  output reg_idx_t wb_rd,
  output logic     wb_reg_write,
  output word_t    wb_data,
  output logic     is_halted
);

  logic [$clog2(`DMEM_WORDS)-1:0] dmem_idx;
  word_t dmem [`DMEM_WORDS];
  word_t result;

  assign dmem_idx = mem_alu_out[$clog2(`DMEM_WORDS)+1:2];  // word addressed

  // nothing younger than the halting ecall may store
  always_ff @(posedge clk) begin
    if (mem_write && !is_halted)
      dmem[dmem_idx] <= mem_store_data;
  end

  assign result = mem_pc_to_reg ? mem_pc_plus4 :
                  mem_read      ? dmem[dmem_idx] : mem_alu_out;

  // MEM/WB control, halt is sticky until reset
  always_ff @(posedge clk) begin
    if (reset) begin
      wb_reg_write <= 1'b0;
      is_halted    <= 1'b0;
    end else begin
      wb_reg_write <= mem_reg_write && !is_halted;
      is_halted    <= is_halted || mem_halt;
    end
  end

  always_ff @(posedge clk) begin
    wb_rd   <= mem_rd;
    wb_data <= result;
  end

endmodule

/* src/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       prog_we,
  input  imem_addr_t prog_addr,
  input  inst_t      prog_data,
  input  reg_idx_t   dbg_reg_idx,
  output logic       is_halted,
  output word_t      dbg_reg_data
);

  // fetch and hazard
  inst_t     id_inst;
  word_t     id_pc, redirect_pc;
  logic      hazard_stall, redirect;
  // decode
  reg_idx_t  rs1_idx, rs2_idx;
  word_t     rs1_data, rs2_data;
  alu_ctrl_t ex_alu_ctrl;
  reg_idx_t  ex_rs1, ex_rs2, ex_rd;
  word_t     ex_rs1_data, ex_rs2_data, ex_imm, ex_pc;
  logic      ex_alu_src, ex_mem_read, ex_mem_write, ex_reg_write, ex_pc_to_reg;
  logic      ex_branch, ex_jal, ex_jalr, ex_halt;
  // execute to memory
  word_t     mem_alu_out, mem_store_data, mem_pc_plus4;
  reg_idx_t  mem_rd;
  logic      mem_read, mem_write, mem_reg_write, mem_pc_to_reg, mem_halt;
  // writeback
  reg_idx_t  wb_rd;
  logic      wb_reg_write;
  word_t     wb_data;

  fetch_stage   u_fetch   (.*);
  decode_stage  u_decode  (.*);
  execute_stage u_execute (.*);
  memory_stage  u_memory  (.*);

  register_file u_regfile (
    .clk          (clk),
    .reset        (reset),
    .rs1_idx      (rs1_idx),
    .rs2_idx      (rs2_idx),
    .rd_idx       (wb_rd),
    .dbg_reg_idx  (dbg_reg_idx),
    .rd_data      (wb_data),
    .reg_write    (wb_reg_write),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .dbg_reg_data (dbg_reg_data)
  );

endmodule

/* tests/cpu_assertions.sv */
`timescale 1ns/1ps

module cpu_assertions import cpu_pkg::*; (
  input logic  clk,
  input logic  reset,
  input logic  is_halted,
  input logic  hazard_stall,
  input logic  redirect,
  input word_t redirect_pc
);

  // halt only clears through reset
  halt_sticky: assert property (@(posedge clk) disable iff (reset)
    is_halted |=> is_halted)
    else $error("is_halted fell outside reset");

  // longest stall is ecall waiting out a7 in EX then MEM
  stall_bounded: assert property (@(posedge clk) disable iff (reset)
    hazard_stall ##1 hazard_stall |=> !hazard_stall)
    else $error("hazard_stall high for more than two cycles");

  redirect_aligned: assert property (@(posedge clk) disable iff (reset)
    redirect |-> redirect_pc[1:0] == 2'b00)   // no compressed ISA here
    else $error("redirect to unaligned pc %h", redirect_pc);

endmodule

bind cpu_top cpu_assertions u_assertions (.*);

/* tests/cpu_tb.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_tb import cpu_pkg::*; ();

  localparam int PROG_RUNS   = 4;
  localparam int BODY_END    = 58;            // slot of the closing addi a7, 10
  localparam int PROG_LEN    = BODY_END + 2;
  localparam int RUN_TIMEOUT = 4000;          // cycles from reset release to halt
  localparam int MODEL_STEPS = 2000;

  logic       clk;
  logic       reset;
  logic       prog_we;
  imem_addr_t prog_addr;
  inst_t      prog_data;
  reg_idx_t   dbg_reg_idx;
  logic       is_halted;
  word_t      dbg_reg_data;

  inst_t prog [PROG_LEN];
  logic  target_hit [PROG_LEN + 4];           // slots some branch or jump lands on
  word_t model_regs [`REG_COUNT];
  word_t model_mem [`DMEM_WORDS];

  cpu_top uut (.*);

  always #2 clk = ~clk;

  task automatic stop_with_failure();
    $display("Finished with errors");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_word(string name, word_t exp, word_t act);
    if (act !== exp) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("ERR %s expected %b actual %b", name, exp, act);
      stop_with_failure();
    end
  endtask

  // rv32i encoders
  function automatic inst_t enc_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                  logic [2:0] f3, reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, `OP_RTYPE};
  endfunction

  function automatic inst_t enc_i(word_t imm, reg_idx_t rs1, logic [2:0] f3,
                                  reg_idx_t rd, logic [6:0] op);
    return {imm[11:0], rs1, f3, rd, op};
  endfunction

  function automatic inst_t enc_s(word_t imm, reg_idx_t rs2, reg_idx_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `OP_STORE};
  endfunction

  function automatic inst_t enc_b(word_t imm, reg_idx_t rs2, reg_idx_t rs1, logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OP_BRANCH};
  endfunction

  function automatic inst_t enc_j(word_t imm, reg_idx_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OP_JAL};
  endfunction

  function automatic reg_idx_t rand_reg(int lo);
    return reg_idx_t'($urandom_range(15, lo));  // up to x15, x17 and x20 kept apart
  endfunction

  function automatic inst_t rand_rtype(reg_idx_t rd, reg_idx_t rs1);
    reg_idx_t rs2;
    rs2 = rand_reg(0);
    case ($urandom_range(5, 0))
      0:       return enc_r(7'h00, rs2, rs1, 3'd0, rd);  // add
      1:       return enc_r(7'h20, rs2, rs1, 3'd0, rd);  // sub
      2:       return enc_r(7'h00, rs2, rs1, 3'd2, rd);  // slt
      3:       return enc_r(7'h00, rs2, rs1, 3'd4, rd);  // xor
      4:       return enc_r(7'h00, rs2, rs1, 3'd6, rd);  // or
      default: return enc_r(7'h00, rs2, rs1, 3'd7, rd);  // and
    endcase
  endfunction

  // random program, forward control flow only, data kept in words 0..7
  task automatic gen_program();
    int       i;
    int       skip;
    int       kind;
    reg_idx_t rd;
    reg_idx_t last_rd;
    last_rd = 5'd1;
    for (i = 0; i < PROG_LEN + 4; i++)
      target_hit[i] = 1'b0;
    for (i = 0; i < 8; i++)
      prog[i] = enc_s(word_t'(i * 4), 5'd0, 5'd0);    // clear the data region
    i = 8;
    while (i < BODY_END) begin
      rd   = rand_reg(0);                             // x0 now and then, must stay zero
      skip = $urandom_range(2, 1);
      kind = $urandom_range(9, 0);
      // multi-slot kinds need room, jalr must not be a landing spot
      if (kind >= 5 && (i + 4 > BODY_END || (kind == 8 && target_hit[i + 1])))
        kind = 3;
      case (kind)
        0, 1, 2: prog[i] = rand_rtype(rd, last_rd);   // chained on last result
        3: prog[i] = enc_i(word_t'($urandom_range(4095, 0)), last_rd, 3'd0, rd, `OP_ITYPE);
        4: prog[i] = enc_s(word_t'(4 * $urandom_range(7, 0)), rand_reg(0), 5'd0);
        5: begin
          prog[i] = enc_i(word_t'(4 * $urandom_range(7, 0)), 5'd0, 3'd2, rd, `OP_LOAD);
          i++;
          prog[i] = rand_rtype(rand_reg(1), rd);      // load-use
        end
        6: begin
          prog[i] = enc_b(word_t'(4 * (skip + 1)), rand_reg(0), last_rd,
                          $urandom_range(1, 0) ? 3'd1 : 3'd0);
          target_hit[i + skip + 1] = 1'b1;
        end
        7: begin
          prog[i] = enc_j(word_t'(4 * (skip + 1)), rd);
          target_hit[i + skip + 1] = 1'b1;
        end
        8: begin
          prog[i] = enc_i(word_t'(4 * (i + skip + 2)), 5'd0, 3'd0, 5'd20, `OP_ITYPE);
          i++;
          prog[i] = enc_i(word_t'(0), 5'd20, 3'd0, rd, `OP_JALR);
          target_hit[i + skip + 1] = 1'b1;
        end
        default: begin
          // a7 below 10, so this ecall must not halt
          prog[i] = enc_i(word_t'($urandom_range(9, 0)), 5'd0, 3'd0, `ECALL_REG, `OP_ITYPE);
          i++;
          prog[i] = 32'h0000_0073;
        end
      endcase
      last_rd = rd;
      i++;
    end
    prog[BODY_END]     = enc_i(`HALT_CODE, 5'd0, 3'd0, `ECALL_REG, `OP_ITYPE);
    prog[BODY_END + 1] = 32'h0000_0073;
  endtask

  // sequential reference, one instruction per step
  task automatic run_model();
    word_t pc;
    word_t npc;
    word_t a;
    word_t b;
    word_t rd_val;
    word_t imm_i;
    word_t imm_s;
    inst_t in;
    logic  wr;
    logic  done;
    int    steps;
    pc   = '0;
    done = 1'b0;
    foreach (model_regs[r])
      model_regs[r] = '0;
    foreach (model_mem[m])
      model_mem[m] = '0;
    for (steps = 0; steps < MODEL_STEPS && !done; steps++) begin
      if (pc[31:2] >= PROG_LEN) begin
        $display("reference model left the program at pc %h", pc);
        stop_with_failure();
      end
      in     = prog[pc[31:2]];
      a      = model_regs[in[19:15]];
      b      = model_regs[in[24:20]];
      imm_i  = {{20{in[31]}}, in[31:20]};
      imm_s  = {{20{in[31]}}, in[31:25], in[11:7]};
      npc    = pc + 4;
      rd_val = pc + 4;                              // link value unless replaced
      wr     = 1'b1;
      case (in[6:0])
        `OP_RTYPE: begin
          case (in[14:12])
            3'd0:    rd_val = in[30] ? a - b : a + b;
            3'd2:    rd_val = word_t'($signed(a) < $signed(b));
            3'd4:    rd_val = a ^ b;
            3'd6:    rd_val = a | b;
            default: rd_val = a & b;
          endcase
        end
        `OP_ITYPE: rd_val = a + imm_i;
        `OP_LOAD:  rd_val = model_mem[(a + imm_i) >> 2];
        `OP_STORE: begin
          model_mem[(a + imm_s) >> 2] = b;
          wr = 1'b0;
        end
        `OP_BRANCH: begin
          if ((a == b) != in[12])                   // beq taken on equal, bne on differ
            npc = pc + {{19{in[31]}}, in[31], in[7], in[30:25], in[11:8], 1'b0};
          wr = 1'b0;
        end
        `OP_JAL:  npc = pc + {{11{in[31]}}, in[31], in[19:12], in[20], in[30:21], 1'b0};
        `OP_JALR: npc = (a + imm_i) & ~word_t'(1);
        default: begin                              // ecall
          done = (model_regs[`ECALL_REG] == `HALT_CODE);
          wr   = 1'b0;
        end
      endcase
      if (wr && in[11:7] != 5'd0)
        model_regs[in[11:7]] = rd_val;
      pc = npc;
    end
    if (!done) begin
      $display("reference model never reached the halting ecall");
      stop_with_failure();
    end
  endtask

  task automatic run_program(int p);
    int i;
    int cyc;
    // load all of imem while in reset, regs must read zero meanwhile
    for (i = 0; i < `IMEM_WORDS; i++) begin
      @(posedge clk);
      reset       <= 1'b1;
      prog_we     <= 1'b1;
      prog_addr   <= imem_addr_t'(i);
      dbg_reg_idx <= reg_idx_t'(i);
      if (i < PROG_LEN)
        prog_data <= prog[i];
      else
        prog_data <= '0;                            // bubbles past the program
      @(negedge clk);
      check_word($sformatf("reset x%0d", i % 32), '0, dbg_reg_data);
    end
    for (i = 0; i < 8; i++) begin
      @(posedge clk);
      prog_we     <= 1'b0;
      dbg_reg_idx <= '0;
      @(negedge clk);
      check_flag("is_halted in reset", 1'b0, is_halted);
    end
    @(posedge clk);
    reset <= 1'b0;
    cyc = 0;
    do begin
      @(negedge clk);
      check_word("x0 while running", '0, dbg_reg_data);
      cyc++;
    end while (!is_halted && cyc < RUN_TIMEOUT);
    if (!is_halted) begin
      $display("program %0d did not halt within %0d cycles", p, RUN_TIMEOUT);
      stop_with_failure();
    end
    for (i = 0; i < `REG_COUNT; i++) begin
      @(posedge clk);
      dbg_reg_idx <= reg_idx_t'(i);
      @(negedge clk);
      check_word($sformatf("prog%0d x%0d", p, i), model_regs[i], dbg_reg_data);
      check_flag("is_halted held", 1'b1, is_halted);
    end
  endtask

  initial begin
    int p;
    clk         = 1'b0;
    reset       = 1'b1;
    prog_we     = 1'b0;
    prog_addr   = '0;
    prog_data   = '0;
    dbg_reg_idx = '0;
    void'($urandom(9527));
    for (p = 0; p < PROG_RUNS; p++) begin
      gen_program();
      run_model();
      run_program(p);
    end
    $display("Finished with no errors");
    $finish;
  end

endmodule

/* flist.f */
+incdir+src
src/cpu_pkg.sv
src/fetch_stage.sv
src/register_file.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/cpu_top.sv
tests/cpu_assertions.sv
tests/cpu_tb.sv
